/* include/soc_params.svh */
// Peripheral SoC parameters
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////

`define SOC_ADR_W       16
`define SOC_DAT_W       32

////////////////////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////////////////////

// data memory at 0x0000, 4KB
`define SOC_MEM_WORDS   1024
// peripheral regions, 64 bytes each
`define SOC_GPIO_BASE   16'h8000
`define SOC_UART_BASE   16'h8040
`define SOC_PER_SIZE    64

// GPIO register offsets
`define SOC_GPIO_OUT    6'h00
`define SOC_GPIO_ENA    6'h04
`define SOC_GPIO_INP    6'h08

// UART register offsets
`define SOC_UART_DAT    6'h00
`define SOC_UART_STS    6'h04

////////////////////////////////////////////////////////////////////////////
// UART
////////////////////////////////////////////////////////////////////////////

// clock cycles per bit, short for simulation
`define SOC_UART_BDR    8
// transmit FIFO depth, power of two
`define SOC_UART_FIFO   4

`endif

/* logic/soc_pkg.sv */
// Peripheral SoC types
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

    // bus vectors
    typedef logic [`SOC_ADR_W-1:0]   adr_t;
    typedef logic [`SOC_DAT_W-1:0]   dat_t;
    typedef logic [`SOC_DAT_W/8-1:0] ben_t;

    // one UART character
    typedef logic [7:0] byte_t;

    // decoder targets
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_GPIO,
        TGT_UART,
        TGT_NONE
    } tgt_e;

    // UART serializer
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage: soc_pkg

`default_nettype wire

/* logic/tcb_if.sv */
// System bus interface
`timescale 1ns/10ps
`default_nettype none

interface tcb_if
    import soc_pkg::*;
(
    input logic clk
);

    // request, from manager
    logic vld;
    logic wen;
    adr_t adr;
    ben_t ben;
    dat_t wdt;
    // handshake and response, from subordinate
    logic rdy;
    dat_t rdt;
    logic err;

    // manager side
    modport man (
        input  clk,
        output vld, wen, adr, ben, wdt,
        input  rdy, rdt, err
    );

    // subordinate side
    modport sub (
        input  clk,
        input  vld, wen, adr, ben, wdt,
        output rdy, rdt, err
    );

endinterface: tcb_if

`default_nettype wire

/* logic/tcb_decoder.sv */
// System bus decoder
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module tcb_decoder
    import soc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    tcb_if.sub   sub,
    tcb_if.man   mem,
    tcb_if.man   gpio,
    tcb_if.man   uart
);

    // end of memory region, in bytes
    localparam adr_t MEM_END = adr_t'(`SOC_MEM_WORDS * (`SOC_DAT_W / 8));
    // region base mask for peripherals
    localparam adr_t PER_MSK = ~adr_t'(`SOC_PER_SIZE - 1);

    tgt_e req_tgt;
    tgt_e rsp_tgt;
    logic run;
    logic trn;

////////////////////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////////////////////

    // address classification
    always_comb begin
        if (sub.adr < MEM_END) begin
            req_tgt = TGT_MEM;
        end else if ((sub.adr & PER_MSK) == adr_t'(`SOC_GPIO_BASE)) begin
            req_tgt = TGT_GPIO;
        end else if ((sub.adr & PER_MSK) == adr_t'(`SOC_UART_BASE)) begin
            req_tgt = TGT_UART;
        end else begin
            req_tgt = TGT_NONE;
        end
    end

    // vld only toward selected target
    assign mem.vld  = sub.vld & (req_tgt == TGT_MEM);
    assign gpio.vld = sub.vld & (req_tgt == TGT_GPIO);
    assign uart.vld = sub.vld & (req_tgt == TGT_UART);

    // shared request fields
    assign mem.wen  = sub.wen;
    assign mem.adr  = sub.adr;
    assign mem.ben  = sub.ben;
    assign mem.wdt  = sub.wdt;
    assign gpio.wen = sub.wen;
    assign gpio.adr = sub.adr;
    assign gpio.ben = sub.ben;
    assign gpio.wdt = sub.wdt;
    assign uart.wen = sub.wen;
    assign uart.adr = sub.adr;
    assign uart.ben = sub.ben;
    assign uart.wdt = sub.wdt;

    // bus enabled once out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // ready from addressed target, unmapped always accepts
    always_comb begin
        case (req_tgt)
            TGT_MEM:  sub.rdy = run & mem.rdy;
            TGT_GPIO: sub.rdy = run & gpio.rdy;
            TGT_UART: sub.rdy = run & uart.rdy;
            default:  sub.rdy = run;
        endcase
    end

    assign trn = sub.vld & sub.rdy;

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

    // accepted target, memory never errs so err is low out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_tgt <= TGT_MEM;
        end else if (trn) begin
            rsp_tgt <= req_tgt;
        end
    end

    // response mux, error with zero data when unmapped
    always_comb begin
        case (rsp_tgt)
            TGT_MEM: begin
                sub.rdt = mem.rdt;
                sub.err = mem.err;
            end
            TGT_GPIO: begin
                sub.rdt = gpio.rdt;
                sub.err = gpio.err;
            end
            TGT_UART: begin
                sub.rdt = uart.rdt;
                sub.err = uart.err;
            end
            default: begin
                sub.rdt = '0;
                sub.err = 1'b1;
            end
        endcase
    end

endmodule: tcb_decoder

`default_nettype wire

/* logic/soc_memory.sv */
// Data memory
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module soc_memory
    import soc_pkg::*;
(
    input  logic clk,
    tcb_if.sub   sub
);

    // byte lanes and word index width
    localparam int unsigned BEN_W = $bits(ben_t);
    localparam int unsigned OFS_W = $clog2(BEN_W);
    localparam int unsigned IDX_W = $clog2(`SOC_MEM_WORDS);

    dat_t             mem_array [0:`SOC_MEM_WORDS-1];
    logic [IDX_W-1:0] idx;
    logic             trn;

    // word address, byte offset dropped
    assign idx = sub.adr[IDX_W+OFS_W-1:OFS_W];

    // memory never stalls or errs
    assign sub.rdy = 1'b1;
    assign sub.err = 1'b0;

    assign trn = sub.vld & sub.rdy;

    // byte writes under ben
    always_ff @(posedge clk) begin
        if (trn & sub.wen) begin
            for (int i = 0; i < BEN_W; i++) begin
                if (sub.ben[i]) begin
                    mem_array[idx][8*i +: 8] <= sub.wdt[8*i +: 8];
                end
            end
        end
    end

    // registered read, held until next read
    always_ff @(posedge clk) begin
        if (trn & ~sub.wen) begin
            sub.rdt <= mem_array[idx];
        end
    end

endmodule: soc_memory

`default_nettype wire

/* logic/gpio_ctrl.sv */
// GPIO controller
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module gpio_ctrl
    import soc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    tcb_if.sub   sub,
    output dat_t gpio_o,
    output dat_t gpio_e,
    input  dat_t gpio_i
);

    localparam int unsigned OFS_W = $clog2(`SOC_PER_SIZE);

    logic [OFS_W-1:0] ofs;
    logic             trn;
    dat_t             gpio_s;
    dat_t             gpio_r;

    // byte merge of write data into a register
    function automatic dat_t merge(dat_t old, dat_t wdt, ben_t ben);
        dat_t res;
        res = old;
        for (int i = 0; i < $bits(ben_t); i++) begin
            if (ben[i]) begin
                res[8*i +: 8] = wdt[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign ofs = sub.adr[OFS_W-1:0];

    // always ready, no errors
    assign sub.rdy = 1'b1;
    assign sub.err = 1'b0;

    assign trn = sub.vld & sub.rdy;

////////////////////////////////////////////////////////////////////////////
// registers
////////////////////////////////////////////////////////////////////////////

    // output and enable, input register is read only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (trn & sub.wen) begin
            if (ofs == OFS_W'(`SOC_GPIO_OUT)) begin
                gpio_o <= merge(gpio_o, sub.wdt, sub.ben);
            end
            if (ofs == OFS_W'(`SOC_GPIO_ENA)) begin
                gpio_e <= merge(gpio_e, sub.wdt, sub.ben);
            end
        end
    end

    // two stage input synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_s <= '0;
            gpio_r <= '0;
        end else begin
            gpio_s <= gpio_i;
            gpio_r <= gpio_s;
        end
    end

    // read mux, unused offsets give zero
    always_ff @(posedge clk) begin
        if (trn & ~sub.wen) begin
            case (ofs)
                OFS_W'(`SOC_GPIO_OUT): sub.rdt <= gpio_o;
                OFS_W'(`SOC_GPIO_ENA): sub.rdt <= gpio_e;
                OFS_W'(`SOC_GPIO_INP): sub.rdt <= gpio_r;
                default:               sub.rdt <= '0;
            endcase
        end
    end

endmodule: gpio_ctrl

`default_nettype wire

/* logic/uart_tx_ctrl.sv */
// UART transmitter
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module uart_tx_ctrl
    import soc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    tcb_if.sub   sub,
    output logic uart_txd
);

    localparam int unsigned OFS_W = $clog2(`SOC_PER_SIZE);
    localparam int unsigned PTR_W = $clog2(`SOC_UART_FIFO);
    localparam int unsigned BDR_W = $clog2(`SOC_UART_BDR);

    logic [OFS_W-1:0] ofs;
    logic             trn;
    logic             push;
    logic             pop;
    // FIFO, head byte stays in place while it is sent
    byte_t            fifo_mem [0:`SOC_UART_FIFO-1];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic             full;
    logic             empty;
    logic             last;
    // serializer
    uart_state_e      state;
    logic [BDR_W-1:0] bdr_cnt;
    logic             bit_end;
    logic [2:0]       bit_idx;
    logic             idle;

    assign ofs = sub.adr[OFS_W-1:0];

    // stall only data writes into a full FIFO
    assign sub.rdy = ~(sub.wen & (ofs == OFS_W'(`SOC_UART_DAT)) & full);
    assign sub.err = 1'b0;

    assign trn  = sub.vld & sub.rdy;
    assign push = trn & sub.wen & (ofs == OFS_W'(`SOC_UART_DAT));

////////////////////////////////////////////////////////////////////////////
// transmit FIFO
////////////////////////////////////////////////////////////////////////////

    // wrap bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    // one entry left, the one on the line
    assign last  = (rd_ptr + 1'b1 == wr_ptr);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr[PTR_W-1:0]] <= sub.wdt[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

////////////////////////////////////////////////////////////////////////////
// serializer
////////////////////////////////////////////////////////////////////////////

    assign bit_end = (bdr_cnt == BDR_W'(`SOC_UART_BDR - 1));
    // entry freed at end of stop bit
    assign pop     = (state == UART_STOP) & bit_end;
    assign idle    = empty & (state == UART_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            bdr_cnt <= '0;
            bit_idx <= '0;
        end else begin
            // baud counter runs inside a frame
            if ((state == UART_IDLE) || bit_end) begin
                bdr_cnt <= '0;
            end else begin
                bdr_cnt <= bdr_cnt + 1'b1;
            end
            case (state)
                UART_IDLE: begin
                    if (!empty) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state   <= UART_DATA;
                        bit_idx <= '0;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                default: begin
                    // back to back while more bytes wait
                    if (bit_end) begin
                        state <= last ? UART_IDLE : UART_START;
                    end
                end
            endcase
        end
    end

    // registered line, lsb first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_txd <= 1'b1;
        end else begin
            case (state)
                UART_START: uart_txd <= 1'b0;
                UART_DATA:  uart_txd <= fifo_mem[rd_ptr[PTR_W-1:0]][bit_idx];
                default:    uart_txd <= 1'b1;
            endcase
        end
    end

    // status is {idle, full}, data register reads zero
    always_ff @(posedge clk) begin
        if (trn & ~sub.wen) begin
            if (ofs == OFS_W'(`SOC_UART_STS)) begin
                sub.rdt <= {{($bits(dat_t)-2){1'b0}}, idle, full};
            end else begin
                sub.rdt <= '0;
            end
        end
    end

endmodule: uart_tx_ctrl

`default_nettype wire

/* logic/periph_soc_top.sv */
// Peripheral SoC top level
`timescale 1ns/10ps
`default_nettype none

module periph_soc_top
    import soc_pkg::*;
(
    // system
    input  logic clk,
    input  logic rst_n,
    // system bus, manager outside
    input  logic tcb_vld,
    input  logic tcb_wen,
    input  adr_t tcb_adr,
    input  ben_t tcb_ben,
    input  dat_t tcb_wdt,
    output logic tcb_rdy,
    output dat_t tcb_rdt,
    output logic tcb_err,
    // GPIO pins
    output dat_t gpio_o,
    output dat_t gpio_e,
    input  dat_t gpio_i,
    // UART line
    output logic uart_txd
);

////////////////////////////////////////////////////////////////////////////
// buses
////////////////////////////////////////////////////////////////////////////

    tcb_if tcb_sys  (.clk (clk));
    tcb_if tcb_mem  (.clk (clk));
    tcb_if tcb_gpio (.clk (clk));
    tcb_if tcb_uart (.clk (clk));

    // plain ports onto system bus
    assign tcb_sys.vld = tcb_vld;
    assign tcb_sys.wen = tcb_wen;
    assign tcb_sys.adr = tcb_adr;
    assign tcb_sys.ben = tcb_ben;
    assign tcb_sys.wdt = tcb_wdt;
    assign tcb_rdy     = tcb_sys.rdy;
    assign tcb_rdt     = tcb_sys.rdt;
    assign tcb_err     = tcb_sys.err;

////////////////////////////////////////////////////////////////////////////
// interconnect and peripherals
////////////////////////////////////////////////////////////////////////////

    tcb_decoder dec (
        .clk   (clk),
        .rst_n (rst_n),
        .sub   (tcb_sys),
        .mem   (tcb_mem),
        .gpio  (tcb_gpio),
        .uart  (tcb_uart)
    );

    soc_memory mem (
        .clk (clk),
        .sub (tcb_mem)
    );

    gpio_ctrl gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .sub    (tcb_gpio),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    uart_tx_ctrl uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .sub      (tcb_uart),
        .uart_txd (uart_txd)
    );

endmodule: periph_soc_top

`default_nettype wire

/* test/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 2
)(
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // reset held low for a few edges, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule: tb_clk_gen

`default_nettype wire

/* test/periph_soc_tb.sv */
// Peripheral SoC testbench
`timescale 1ns/10ps
`default_nettype none

`include "soc_params.svh"

module periph_soc_tb
    import soc_pkg::*;
();

////////////////////////////////////////////////////////////////////////////
// constants
////////////////////////////////////////////////////////////////////////////

    localparam int   BDR       = `SOC_UART_BDR;
    localparam int   UART_FIFO = `SOC_UART_FIFO;
    localparam int   IDX_W     = $clog2(`SOC_MEM_WORDS);
    localparam int   OFS_W     = $clog2(`SOC_PER_SIZE);
    localparam adr_t MEM_BYTES = adr_t'(`SOC_MEM_WORDS * $bits(ben_t));
    localparam adr_t GPIO_BASE = `SOC_GPIO_BASE;
    localparam adr_t UART_BASE = `SOC_UART_BASE;
    localparam adr_t GPIO_OUT  = GPIO_BASE + adr_t'(`SOC_GPIO_OUT);
    localparam adr_t GPIO_ENA  = GPIO_BASE + adr_t'(`SOC_GPIO_ENA);
    localparam adr_t GPIO_INP  = GPIO_BASE + adr_t'(`SOC_GPIO_INP);
    localparam adr_t GPIO_NONE = GPIO_BASE + adr_t'(16'h000c);
    localparam adr_t UART_DAT  = UART_BASE + adr_t'(`SOC_UART_DAT);
    localparam adr_t UART_STS  = UART_BASE + adr_t'(`SOC_UART_STS);
    localparam adr_t UART_NONE = UART_BASE + adr_t'(16'h0008);
    // hole between memory and peripherals
    localparam adr_t UNMAPPED  = 16'h4000;

    localparam int NUM_WORDS = 32;
    localparam int NUM_CHARS = 5;
    // about 300 bus cycles plus the frames, doubled, plus slack
    localparam int BUS_CYCLES     = 300;
    localparam int FRAME_CYCLES   = 10 * BDR;
    localparam int TIMEOUT_CYCLES = 2 * (BUS_CYCLES + NUM_CHARS * FRAME_CYCLES) + 600;

    logic clk;
    logic rst_n;
    // bus manager side
    logic tcb_vld;
    logic tcb_wen;
    adr_t tcb_adr;
    ben_t tcb_ben;
    dat_t tcb_wdt;
    logic tcb_rdy;
    dat_t tcb_rdt;
    logic tcb_err;
    // pins
    dat_t gpio_o;
    dat_t gpio_e;
    dat_t gpio_i;
    logic uart_txd;

    // reference state
    dat_t  ref_mem [0:`SOC_MEM_WORDS-1];
    dat_t  sh_gpio_o = '0;
    dat_t  sh_gpio_e = '0;
    dat_t  sh_gpio_i = '0;
    byte_t exp_q [$];

    logic [31:0] lfsr_q       = 32'h696d;
    int          value_errors = 0;
    int          other_errors = 0;
    int          rx_count     = 0;
    logic        in_frame     = 1'b0;
    int          cycle_cnt    = 0;

    tb_clk_gen #(.PERIOD (20), .RST_CYCLES (2)) clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    periph_soc_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .tcb_vld  (tcb_vld),
        .tcb_wen  (tcb_wen),
        .tcb_adr  (tcb_adr),
        .tcb_ben  (tcb_ben),
        .tcb_wdt  (tcb_wdt),
        .tcb_rdy  (tcb_rdy),
        .tcb_rdt  (tcb_rdt),
        .tcb_err  (tcb_err),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_txd)
    );

////////////////////////////////////////////////////////////////////////////
// random numbers and reference model
////////////////////////////////////////////////////////////////////////////

    // galois shift, one output bit per step
    function automatic logic lfsr_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'ha3000000;
        end
        return b;
    endfunction

    function automatic dat_t rand_bits(int n);
        dat_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[$bits(dat_t)-2:0], lfsr_bit()};
        end
        return r;
    endfunction

    // write side of the model, masks built from the byte enables
    function automatic void ref_write(adr_t adr, ben_t ben, dat_t wdt);
        dat_t mask;
        mask = {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
        if (adr < MEM_BYTES) begin
            ref_mem[adr[IDX_W+1:2]] = (ref_mem[adr[IDX_W+1:2]] & ~mask) | (wdt & mask);
        end else if (adr == GPIO_OUT) begin
            sh_gpio_o = (sh_gpio_o & ~mask) | (wdt & mask);
        end else if (adr == GPIO_ENA) begin
            sh_gpio_e = (sh_gpio_e & ~mask) | (wdt & mask);
        end
        // input and status registers ignore writes
    endfunction

    // expected read data and err from the address map
    function automatic dat_t ref_read(input adr_t adr, output logic err);
        logic [OFS_W-1:0] ofs;
        dat_t             dat;
        ofs = adr[OFS_W-1:0];
        dat = '0;
        err = 1'b0;
        if (adr < MEM_BYTES) begin
            dat = ref_mem[adr[IDX_W+1:2]];
        end else if (adr[`SOC_ADR_W-1:OFS_W] == GPIO_BASE[`SOC_ADR_W-1:OFS_W]) begin
            case (ofs)
                `SOC_GPIO_OUT: dat = sh_gpio_o;
                `SOC_GPIO_ENA: dat = sh_gpio_e;
                `SOC_GPIO_INP: dat = sh_gpio_i;
                default:       dat = '0;
            endcase
        end else if (adr[`SOC_ADR_W-1:OFS_W] == UART_BASE[`SOC_ADR_W-1:OFS_W]) begin
            // quiet line: idle set, full clear
            if (ofs == `SOC_UART_STS) begin
                dat = dat_t'(2);
            end
        end else begin
            err = 1'b1;
        end
        return dat;
    endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

    task automatic check_dat(input dat_t got, input dat_t exp, input string msg);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t: %s, err %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string msg);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // single line levels
    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t: %s, level %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

////////////////////////////////////////////////////////////////////////////
// bus manager
////////////////////////////////////////////////////////////////////////////

    // request at a rising edge, rdy seen at the falling edge,
    // response sampled one cycle after acceptance
    task automatic bus_xfer(
        input  logic wen,
        input  adr_t adr,
        input  ben_t ben,
        input  dat_t wdt,
        output dat_t rdt,
        output logic err,
        output int   waits
    );
        waits = 0;
        @(posedge clk);
        tcb_vld <= 1'b1;
        tcb_wen <= wen;
        tcb_adr <= adr;
        tcb_ben <= ben;
        tcb_wdt <= wdt;
        @(negedge clk);
        while (tcb_rdy !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        // acceptance edge
        @(posedge clk);
        tcb_vld <= 1'b0;
        @(negedge clk);
        rdt = tcb_rdt;
        err = tcb_err;
    endtask

    task automatic write_expect(input adr_t adr, input ben_t ben, input dat_t wdt,
                                input string msg);
        dat_t rdt;
        logic err;
        logic exp_err;
        int   waits;
        void'(ref_read(adr, exp_err));
        bus_xfer(1'b1, adr, ben, wdt, rdt, err, waits);
        ref_write(adr, ben, wdt);
        check_err(err, exp_err, msg);
    endtask

    task automatic read_expect(input adr_t adr, input string msg);
        dat_t rdt;
        dat_t exp;
        logic err;
        logic exp_err;
        int   waits;
        bus_xfer(1'b0, adr, ben_t'('1), '0, rdt, err, waits);
        exp = ref_read(adr, exp_err);
        check_dat(rdt, exp, msg);
        check_err(err, exp_err, msg);
    endtask

////////////////////////////////////////////////////////////////////////////
// UART line monitor
////////////////////////////////////////////////////////////////////////////

    initial begin : uart_monitor
        byte_t rx;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            in_frame = 1'b1;
            // middle of start bit
            repeat (BDR/2) @(negedge clk);
            check_bit(uart_txd, 1'b0, "uart start bit");
            // lsb first
            for (int i = 0; i < 8; i++) begin
                repeat (BDR) @(negedge clk);
                rx[i] = uart_txd;
            end
            repeat (BDR) @(negedge clk);
            check_bit(uart_txd, 1'b1, "uart stop bit");
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("uart sent character %h that nobody wrote", rx);
            end else begin
                check_byte(rx, exp_q.pop_front(), "uart character");
            end
            rx_count++;
            @(posedge clk);
            in_frame = 1'b0;
        end
    end

////////////////////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        adr_t  mem_adr [NUM_WORDS];
        dat_t  rdt;
        dat_t  sts;
        logic  err;
        int    waits;
        byte_t ch;
        tcb_vld <= 1'b0;
        tcb_wen <= 1'b0;
        tcb_adr <= '0;
        tcb_ben <= '0;
        tcb_wdt <= '0;
        gpio_i  <= '0;

        // reset values
        @(negedge clk);
        check_bit(tcb_rdy, 1'b0, "rdy during reset");
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_dat(gpio_o, '0, "gpio_o after reset");
        check_dat(gpio_e, '0, "gpio_e after reset");
        check_bit(uart_txd, 1'b1, "uart_txd after reset");
        check_err(tcb_err, 1'b0, "err after reset");
        read_expect(UART_STS, "uart status after reset");

        // memory, full word first so no byte stays unknown
        for (int i = 0; i < NUM_WORDS; i++) begin
            mem_adr[i] = adr_t'(rand_bits(IDX_W)) << 2;
            write_expect(mem_adr[i], ben_t'('1), rand_bits(32), "memory fill");
            write_expect(mem_adr[i], ben_t'(rand_bits(4)), rand_bits(32), "memory byte write");
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            read_expect(mem_adr[i], "memory readback");
        end

        // gpio registers under partial enables
        write_expect(GPIO_OUT, 4'hf, rand_bits(32), "gpio out write");
        write_expect(GPIO_OUT, 4'b0110, rand_bits(32), "gpio out partial write");
        write_expect(GPIO_ENA, 4'b1001, rand_bits(32), "gpio enable partial write");
        write_expect(GPIO_ENA, 4'b0100, rand_bits(32), "gpio enable byte write");
        check_dat(gpio_o, sh_gpio_o, "gpio_o pins");
        check_dat(gpio_e, sh_gpio_e, "gpio_e pins");
        read_expect(GPIO_OUT, "gpio out readback");
        read_expect(GPIO_ENA, "gpio enable readback");
        // input through the synchronizer
        @(posedge clk);
        sh_gpio_i = rand_bits(32);
        gpio_i <= sh_gpio_i;
        repeat (4) @(posedge clk);
        read_expect(GPIO_INP, "gpio input read");
        write_expect(GPIO_INP, 4'hf, ~sh_gpio_i, "gpio input write");
        read_expect(GPIO_INP, "gpio input after write");

        // unmapped and unused offsets
        read_expect(UNMAPPED, "unmapped read");
        bus_xfer(1'b1, UNMAPPED, 4'hf, rand_bits(32), rdt, err, waits);
        check_dat(rdt, '0, "unmapped write data");
        check_err(err, 1'b1, "unmapped write");
        read_expect(GPIO_NONE, "unused gpio offset");
        read_expect(UART_NONE, "unused uart offset");
        write_expect(UART_STS, 4'hf, '1, "uart status write");

        // uart characters, the fifth one waits for a free entry
        for (int i = 0; i < NUM_CHARS; i++) begin
            ch = byte_t'(rand_bits(8));
            exp_q.push_back(ch);
            bus_xfer(1'b1, UART_DAT, 4'h1, dat_t'(ch), rdt, err, waits);
            check_err(err, 1'b0, "uart data write");
            if ((i < UART_FIFO) && (waits != 0)) begin
                other_errors++;
                $display("uart write %0d stalled while the FIFO had room", i);
            end else if ((i == UART_FIFO) && (waits == 0)) begin
                other_errors++;
                $display("uart write %0d went into a full FIFO without a stall", i);
            end
        end

        // poll until idle, never idle mid frame
        do begin
            bus_xfer(1'b0, UART_STS, 4'hf, '0, sts, err, waits);
            check_err(err, 1'b0, "uart status poll");
            check_dat(sts & ~dat_t'(3), '0, "uart status unused bits");
            if (sts[1] && in_frame) begin
                other_errors++;
                $display("uart status read idle while a frame was on the line");
            end
        end while (!sts[1]);
        if ((exp_q.size() != 0) || (rx_count != NUM_CHARS)) begin
            other_errors++;
            $display("only %0d of %0d uart characters arrived", rx_count, NUM_CHARS);
        end
        check_bit(uart_txd, 1'b1, "uart_txd at end");
        read_expect(UART_STS, "uart status at end");

        print_summary();
        if ((value_errors + other_errors) == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // cycle limit
    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errors++;
        $display("run stopped after %0d clock cycles without finishing", cycle_cnt);
        print_summary();
        $display("sim failed");
        $finish;
    end

endmodule: periph_soc_tb

`default_nettype wire

/* periph_soc_top.f */
+incdir+include
logic/soc_pkg.sv
logic/tcb_if.sv
logic/tcb_decoder.sv
logic/soc_memory.sv
logic/gpio_ctrl.sv
logic/uart_tx_ctrl.sv
logic/periph_soc_top.sv
test/tb_clk_gen.sv
test/periph_soc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module periph_soc_tb \
    -f periph_soc_top.f -Mdir obj_dir -o periph_soc_sim

./obj_dir/periph_soc_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"
